// ==== id_stage.f ====
rv_isa_pkg.sv
id_pipe_pkg.sv
regfile.sv
imm_gen.sv
branch_cmp.sv
hazard_ctrl.sv
id_decode.sv
id_stage.sv
tb_id_stage.sv

// ==== Makefile ====
# Verilator build and run of the decode stage testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, non-zero status on a reported failure"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -sv --top-module tb_id_stage -f id_stage.f -Mdir obj_dir
	./obj_dir/Vtb_id_stage > sim.log
	@cat sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== tb_id_stage.sv ====
// ==============================
// Decode stage testbench driving random and directed traffic against a model
// ==============================

`timescale 1ns/1ns

module tb_id_stage;

  import rv_isa_pkg::*;
  import id_pipe_pkg::*;

  logic              clk;
  logic              rstz;
  logic              flush;
  logic [XLEN-1:0]   fetch_pc;
  logic [XLEN-1:0]   fetch_ir;
  logic              fetch_vld;
  logic              fetch_rdy;
  logic              regwr_en;
  logic [REG_AW-1:0] regwr_sel;
  logic [XLEN-1:0]   regwr_data;
  logic [XLEN-1:0]   decode_pc;
  logic [XLEN-1:0]   decode_ir;
  aluop_e            decode_aluop;
  logic [XLEN-1:0]   decode_op1;
  logic [XLEN-1:0]   decode_op2;
  logic [XLEN-1:0]   decode_addr;
  logic              decode_regwr_alu;
  logic              decode_jump;
  logic              decode_branch;
  logic              decode_vld;
  logic              decode_rdy;

  // Model of register file and scoreboard
  logic [XLEN-1:0]     model_regs [NUM_REGS];
  logic [NUM_REGS-1:0] model_busy;
  // Destinations still waiting for writeback
  logic [REG_AW-1:0]   pend_q [$];

  // Expected decode record
  logic            exp_vld;
  logic [XLEN-1:0] exp_pc;
  logic [XLEN-1:0] exp_ir;
  logic [XLEN-1:0] exp_op1;
  logic [XLEN-1:0] exp_op2;
  logic [XLEN-1:0] exp_addr;
  aluop_e          exp_aluop;
  logic            exp_regwr;
  logic            exp_jump;
  logic            exp_branch;

  integer seed;
  int     n_err;
  int     n_tests;
  int     n_accept;
  int     n_deliver;
  int     n_drop;
  logic   last_acc;

  id_stage dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ==============================
  // Compare tasks
  // ==============================

  task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                            input string what);
    if (got !== exp) begin
      n_err++;
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_aluop(input aluop_e got, input aluop_e exp, input string what);
    if (got !== exp) begin
      n_err++;
      $display("[FAIL] %0t ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      n_err++;
      $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // ==============================
  // Reference model
  // ==============================

  // Immediate by format from the ISA bit layout
  function automatic logic [XLEN-1:0] ref_imm(input logic [XLEN-1:0] ir);
    opcode_e op;
    op = opcode_e'(ir[6:2]);
    case (op)
      OP_OPIMM, OP_JALR: ref_imm = {{20{ir[31]}}, ir[31:20]};
      OP_BRANCH:         ref_imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
      OP_LUI, OP_AUIPC:  ref_imm = {ir[31:12], 12'h000};
      OP_JAL:            ref_imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
      default:           ref_imm = '0;
    endcase
  endfunction

  // Source value with same-cycle writeback
  function automatic logic [XLEN-1:0] src_val(input logic [REG_AW-1:0] r);
    if (r == '0) begin
      src_val = '0;
    end else if (regwr_en && (regwr_sel == r)) begin
      src_val = regwr_data;
    end else begin
      src_val = model_regs[r];
    end
  endfunction

  function automatic logic src_blocked(input logic [REG_AW-1:0] r);
    src_blocked = model_busy[r] && !(regwr_en && (regwr_sel == r));
  endfunction

  function automatic logic ref_taken(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                     input logic [XLEN-1:0] b);
    case (f3)
      3'b000:  ref_taken = (a == b);
      3'b001:  ref_taken = (a != b);
      3'b100:  ref_taken = ($signed(a) < $signed(b));
      3'b101:  ref_taken = ($signed(a) >= $signed(b));
      3'b110:  ref_taken = (a < b);
      3'b111:  ref_taken = (a >= b);
      default: ref_taken = 1'b0;
    endcase
  endfunction

  // Record for the instruction on the fetch port
  task automatic predict_record();
    opcode_e         op;
    logic [2:0]      f3;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    op  = opcode_e'(fetch_ir[6:2]);
    f3  = fetch_ir[14:12];
    imm = ref_imm(fetch_ir);
    a   = src_val(fetch_ir[19:15]);
    b   = src_val(fetch_ir[24:20]);
    exp_pc     = fetch_pc;
    exp_ir     = fetch_ir;
    exp_aluop  = ALU_ADD;
    exp_op1    = fetch_pc;
    exp_op2    = WORD_FOUR;
    exp_addr   = fetch_pc + WORD_FOUR;
    exp_jump   = op inside {OP_JAL, OP_JALR};
    exp_branch = (op == OP_BRANCH) && ref_taken(f3, a, b);
    exp_regwr  = (op inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_OPIMM, OP_OP}) &&
                 (fetch_ir[11:7] != 5'd0);
    case (op)
      OP_LUI: begin
        exp_op1 = WORD_ZERO;
        exp_op2 = imm;
      end
      OP_AUIPC: exp_op2 = imm;
      OP_JAL, OP_BRANCH: exp_addr = fetch_pc + imm;
      OP_JALR: begin
        exp_addr    = a + imm;
        exp_addr[0] = 1'b0;
      end
      OP_OPIMM: begin
        exp_op1 = a;
        exp_op2 = imm;
        // funct7 bit 5 counts for shifts only
        if (f3 == 3'b001 || f3 == 3'b101) begin
          exp_aluop = aluop_e'({fetch_ir[30], f3});
        end else begin
          exp_aluop = aluop_e'({1'b0, f3});
        end
      end
      OP_OP: begin
        exp_op1   = a;
        exp_op2   = b;
        exp_aluop = aluop_e'({fetch_ir[30], f3});
      end
      default: begin
      end
    endcase
  endtask

  task automatic check_record();
    check_word(decode_pc, exp_pc, "decode_pc");
    check_word(decode_ir, exp_ir, "decode_ir");
    check_aluop(decode_aluop, exp_aluop, "decode_aluop");
    check_word(decode_op1, exp_op1, "decode_op1");
    check_word(decode_op2, exp_op2, "decode_op2");
    check_word(decode_addr, exp_addr, "decode_addr");
    check_flag(decode_regwr_alu, exp_regwr, "decode_regwr_alu");
    check_flag(decode_jump, exp_jump, "decode_jump");
    check_flag(decode_branch, exp_branch, "decode_branch");
  endtask

  // One clock cycle from 2 ns past a rising edge to 2 ns past the next
  task automatic step();
    opcode_e           op;
    logic [REG_AW-1:0] rd;
    logic              stall_exp;
    logic              rdy_exp;
    logic              acc;
    logic              dut_acc;
    #8;
    op = opcode_e'(fetch_ir[6:2]);
    rd = fetch_ir[11:7];
    stall_exp = ((op inside {OP_JALR, OP_BRANCH, OP_OPIMM, OP_OP}) &&
                 src_blocked(fetch_ir[19:15])) ||
                ((op inside {OP_BRANCH, OP_OP}) && src_blocked(fetch_ir[24:20]));
    rdy_exp = (!exp_vld || decode_rdy) && !stall_exp && !flush;
    check_flag(fetch_rdy, rdy_exp, "fetch_rdy");
    acc     = fetch_vld && rdy_exp;
    // Handshake counters follow the DUT ports
    dut_acc = fetch_vld && fetch_rdy;
    if (decode_vld && decode_rdy) begin
      n_deliver++;
    end else if (decode_vld && flush) begin
      n_drop++;
    end
    if (dut_acc) begin
      n_accept++;
    end
    if (acc) begin
      predict_record();
    end
    if (flush) begin
      exp_vld = 1'b0;
    end else if (acc) begin
      exp_vld = 1'b1;
    end else if (decode_rdy) begin
      exp_vld = 1'b0;
    end
    // New destination wins over a colliding writeback
    if (flush) begin
      model_busy = '0;
      pend_q.delete();
    end else begin
      if (regwr_en) begin
        model_busy[regwr_sel] = 1'b0;
      end
      if (acc && (op inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_OPIMM, OP_OP}) &&
          (rd != 5'd0)) begin
        model_busy[rd] = 1'b1;
        pend_q.push_back(rd);
      end
    end
    if (regwr_en && (regwr_sel != 5'd0)) begin
      model_regs[regwr_sel] = regwr_data;
    end
    last_acc = dut_acc;
    @(posedge clk);
    #2;
    check_flag(decode_vld, exp_vld, "decode_vld");
    if (exp_vld) begin
      check_record();
    end
  endtask

  // ==============================
  // Stimulus
  // ==============================

  // Mostly x0..x3 so hazards come often
  function automatic logic [REG_AW-1:0] pick_reg();
    logic [31:0] r;
    r = $random(seed);
    if (r[3:2] != 2'b00) begin
      pick_reg = {3'b000, r[1:0]};
    end else begin
      pick_reg = r[8:4];
    end
  endfunction

  task automatic gen_instr();
    logic [31:0]     r;
    logic [XLEN-1:0] ir;
    logic [2:0]      f3;
    opcode_e         op;
    r = $random(seed);
    case (r[2:0])
      3'd0:    op = OP_LUI;
      3'd1:    op = OP_AUIPC;
      3'd2:    op = OP_JAL;
      3'd3:    op = OP_JALR;
      3'd4:    op = OP_BRANCH;
      3'd5:    op = OP_OPIMM;
      3'd6:    op = OP_OPIMM;
      default: op = OP_OP;
    endcase
    ir = $random(seed);
    f3 = ir[14:12];
    ir[6:0]   = {op, 2'b11};
    ir[11:7]  = pick_reg();
    ir[19:15] = pick_reg();
    ir[24:20] = pick_reg();
    case (op)
      OP_JALR: ir[14:12] = 3'b000;
      // Reserved branch codes moved to LTU and GEU
      OP_BRANCH: ir[14] = ir[14] | ir[13];
      OP_OPIMM: begin
        if (f3 == 3'b001) begin
          ir[31:25] = 7'd0;
        end else if (f3 == 3'b101) begin
          ir[31:25] = {1'b0, r[3], 5'd0};
        end
      end
      OP_OP: ir[31:25] = {1'b0, r[3] && (f3 == 3'b000 || f3 == 3'b101), 5'd0};
      default: begin
      end
    endcase
    fetch_ir = ir;
    fetch_pc = $random(seed);
    fetch_pc[1:0] = 2'b00;
  endtask

  task automatic random_stim();
    logic [31:0] r;
    int          idx;
    r = $random(seed);
    // Offered instruction held until taken
    if (last_acc || !fetch_vld) begin
      gen_instr();
      fetch_vld = (r[1:0] != 2'b00);
    end
    decode_rdy = (r[3:2] != 2'b00);
    flush      = (r[9:4] == 6'd0);
    regwr_en   = 1'b0;
    regwr_sel  = '0;
    if (pend_q.size() > 0 && r[12]) begin
      idx = {27'd0, r[20:16]};
      idx = idx % pend_q.size();
      regwr_en  = 1'b1;
      regwr_sel = pend_q[idx];
      pend_q.delete(idx);
    end else if (r[15:13] == 3'd0) begin
      // Stray write to x0
      regwr_en = 1'b1;
    end
    regwr_data = $random(seed);
  endtask

  // Write back every pending destination and drain the record
  task automatic retire_pending();
    int cycles;
    cycles     = 0;
    fetch_vld  = 1'b0;
    flush      = 1'b0;
    decode_rdy = 1'b1;
    while ((pend_q.size() > 0 || exp_vld) && cycles < 64) begin
      regwr_en = (pend_q.size() > 0);
      if (regwr_en) begin
        regwr_sel = pend_q.pop_front();
      end
      regwr_data = $random(seed);
      step();
      cycles++;
    end
    regwr_en = 1'b0;
    if (pend_q.size() > 0 || exp_vld) begin
      n_err++;
      $display("Timeout: pipeline did not drain within 64 cycles");
    end
  endtask

  task automatic issue_one(input logic [XLEN-1:0] ir, input logic [XLEN-1:0] pc);
    int cycles;
    cycles     = 0;
    fetch_ir   = ir;
    fetch_pc   = pc;
    fetch_vld  = 1'b1;
    flush      = 1'b0;
    decode_rdy = 1'b1;
    regwr_en   = 1'b0;
    do begin
      step();
      cycles++;
    end while (!last_acc && cycles < 16);
    fetch_vld = 1'b0;
    if (!last_acc) begin
      n_err++;
      $display("Timeout: instruction %h was not accepted within 16 cycles", ir);
    end
  endtask

  task automatic report(input string name, input int err0);
    n_tests++;
    $display("%s test finished with %0d errors", name, n_err - err0);
  endtask

  // ==============================
  // Tests
  // ==============================

  task automatic reset_test();
    int err0;
    err0 = n_err;
    check_flag(decode_vld, 1'b0, "decode_vld after reset");
    fetch_vld  = 1'b0;
    decode_rdy = 1'b1;
    // Idle cycles with fetch_rdy expected high
    for (int i = 0; i < 4; i++) begin
      step();
    end
    report("reset", err0);
  endtask

  task automatic random_test(input int count);
    int err0;
    int acc0;
    int del0;
    int drop0;
    int cycles;
    err0   = n_err;
    acc0   = n_accept;
    del0   = n_deliver;
    drop0  = n_drop;
    cycles = 0;
    while ((n_accept - acc0) < count && cycles < 20 * count) begin
      random_stim();
      step();
      cycles++;
    end
    if ((n_accept - acc0) < count) begin
      n_err++;
      $display("Timeout: only %0d of %0d instructions accepted", n_accept - acc0, count);
    end
    retire_pending();
    // Each accepted instruction leaves once or is flushed
    if ((n_accept - acc0) != (n_deliver - del0) + (n_drop - drop0)) begin
      n_err++;
      $display("Record count mismatch: %0d accepted, %0d delivered, %0d flushed",
               n_accept - acc0, n_deliver - del0, n_drop - drop0);
    end
    report("random", err0);
  endtask

  task automatic hazard_test();
    int err0;
    int acc0;
    err0 = n_err;
    // ADDI x6, x0, 0x123
    issue_one({12'h123, 5'd0, 3'b000, 5'd6, OP_OPIMM, 2'b11}, 32'h0000_0100);
    // ADD x7, x6, x6 waits on x6
    fetch_ir  = {7'd0, 5'd6, 5'd6, 3'b000, 5'd7, OP_OP, 2'b11};
    fetch_pc  = 32'h0000_0104;
    fetch_vld = 1'b1;
    acc0      = n_accept;
    for (int i = 0; i < 3; i++) begin
      step();
    end
    if (n_accept != acc0) begin
      n_err++;
      $display("Instruction with a busy source was accepted before its writeback");
    end
    // Writeback in the accepting cycle is forwarded
    regwr_en   = 1'b1;
    regwr_sel  = 5'd6;
    regwr_data = 32'h5a5a_0006;
    step();
    check_flag(last_acc, 1'b1, "accept with same-cycle writeback");
    // SUB x8, x0, x0 during a write to x0
    fetch_ir   = {7'b0100000, 5'd0, 5'd0, 3'b000, 5'd8, OP_OP, 2'b11};
    regwr_sel  = 5'd0;
    regwr_data = 32'hffff_ffff;
    step();
    check_flag(last_acc, 1'b1, "accept of x0 reader");
    retire_pending();
    report("hazard", err0);
  endtask

  task automatic flush_test();
    int err0;
    err0 = n_err;
    // ADDI x9 makes x9 busy
    issue_one({12'h0ff, 5'd0, 3'b000, 5'd9, OP_OPIMM, 2'b11}, 32'h0000_0200);
    // ADD x10, x9, x1 stalls while execute holds the record
    fetch_ir   = {7'd0, 5'd1, 5'd9, 3'b000, 5'd10, OP_OP, 2'b11};
    fetch_pc   = 32'h0000_0204;
    fetch_vld  = 1'b1;
    decode_rdy = 1'b0;
    step();
    step();
    flush = 1'b1;
    step();
    flush = 1'b0;
    // Empty scoreboard lets the reader straight in
    step();
    check_flag(last_acc, 1'b1, "accept after flush");
    retire_pending();
    report("flush", err0);
  endtask

  // ==============================
  // Main sequence
  // ==============================

  initial begin
    seed       = 10257;
    rstz       = 1'b0;
    flush      = 1'b0;
    fetch_pc   = '0;
    fetch_ir   = '0;
    fetch_vld  = 1'b0;
    regwr_en   = 1'b0;
    regwr_sel  = '0;
    regwr_data = '0;
    decode_rdy = 1'b0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    model_busy = '0;
    exp_vld    = 1'b0;
    last_acc   = 1'b0;
    n_err      = 0;
    n_tests    = 0;
    n_accept   = 0;
    n_deliver  = 0;
    n_drop     = 0;
    repeat (5) @(posedge clk);
    #2;
    rstz = 1'b1;
    reset_test();
    random_test(400);
    hazard_test();
    flush_test();
    $display("%0d tests, %0d accepted, %0d delivered, %0d errors",
             n_tests, n_accept, n_deliver, n_err);
    if (n_err == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== id_stage.sv ====
// ==============================
// Decode stage top, hazard control plus decode datapath
// ==============================

`timescale 1ns/1ns

module id_stage (
  input  logic                           clk,
  input  logic                           rstz,
  input  logic                           flush,
  // Fetch side
  input  logic [id_pipe_pkg::XLEN-1:0]   fetch_pc,
  input  logic [id_pipe_pkg::XLEN-1:0]   fetch_ir,
  input  logic                           fetch_vld,
  output logic                           fetch_rdy,
  // Writeback port
  input  logic                           regwr_en,
  input  logic [id_pipe_pkg::REG_AW-1:0] regwr_sel,
  input  logic [id_pipe_pkg::XLEN-1:0]   regwr_data,
  // Decode record to execute
  output logic [id_pipe_pkg::XLEN-1:0]   decode_pc,
  output logic [id_pipe_pkg::XLEN-1:0]   decode_ir,
  output rv_isa_pkg::aluop_e             decode_aluop,
  output logic [id_pipe_pkg::XLEN-1:0]   decode_op1,
  output logic [id_pipe_pkg::XLEN-1:0]   decode_op2,
  output logic [id_pipe_pkg::XLEN-1:0]   decode_addr,
  output logic                           decode_regwr_alu,
  output logic                           decode_jump,
  output logic                           decode_branch,
  output logic                           decode_vld,
  input  logic                           decode_rdy
);

  import id_pipe_pkg::*;

  // Register usage of the current instruction
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [REG_AW-1:0] rd;
  logic              rs1_used;
  logic              rs2_used;
  logic              rd_write;

  logic              issue;
  logic [XLEN-1:0]   immediate;
  logic [XLEN-1:0]   regrd_rs1;
  logic [XLEN-1:0]   regrd_rs2;

  hazard_ctrl u_hazard_ctrl (
    .clk        (clk),
    .rstz       (rstz),
    .flush      (flush),
    .fetch_vld  (fetch_vld),
    .fetch_rdy  (fetch_rdy),
    .decode_vld (decode_vld),
    .decode_rdy (decode_rdy),
    .rs1_used   (rs1_used),
    .rs2_used   (rs2_used),
    .rd_write   (rd_write),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .regwr_en   (regwr_en),
    .regwr_sel  (regwr_sel),
    .issue      (issue)
  );

  id_decode u_id_decode (
    .clk              (clk),
    .rstz             (rstz),
    .flush            (flush),
    .issue            (issue),
    .decode_rdy       (decode_rdy),
    .fetch_pc         (fetch_pc),
    .fetch_ir         (fetch_ir),
    .immediate        (immediate),
    .regrd_rs1        (regrd_rs1),
    .regrd_rs2        (regrd_rs2),
    .regwr_en         (regwr_en),
    .regwr_sel        (regwr_sel),
    .regwr_data       (regwr_data),
    .rs1              (rs1),
    .rs2              (rs2),
    .rd               (rd),
    .rs1_used         (rs1_used),
    .rs2_used         (rs2_used),
    .rd_write         (rd_write),
    .decode_pc        (decode_pc),
    .decode_ir        (decode_ir),
    .decode_aluop     (decode_aluop),
    .decode_op1       (decode_op1),
    .decode_op2       (decode_op2),
    .decode_addr      (decode_addr),
    .decode_regwr_alu (decode_regwr_alu),
    .decode_jump      (decode_jump),
    .decode_branch    (decode_branch),
    .decode_vld       (decode_vld)
  );

  regfile u_regfile (
    .clk        (clk),
    .rstz       (rstz),
    .rs1        (rs1),
    .rs2        (rs2),
    .regwr_en   (regwr_en),
    .regwr_sel  (regwr_sel),
    .regwr_data (regwr_data),
    .rs1_data   (regrd_rs1),
    .rs2_data   (regrd_rs2)
  );

  imm_gen u_imm_gen (
    .ir        (fetch_ir),
    .immediate (immediate)
  );

endmodule

// ==== id_decode.sv ====
// ==============================
// Decode datapath, builds operands, ALU op and target into the record
// ==============================

`timescale 1ns/1ns

module id_decode (
  input  logic                           clk,
  input  logic                           rstz,
  input  logic                           flush,
  input  logic                           issue,
  input  logic                           decode_rdy,
  // Instruction from fetch
  input  logic [id_pipe_pkg::XLEN-1:0]   fetch_pc,
  input  logic [id_pipe_pkg::XLEN-1:0]   fetch_ir,
  // Immediate and register read data
  input  logic [id_pipe_pkg::XLEN-1:0]   immediate,
  input  logic [id_pipe_pkg::XLEN-1:0]   regrd_rs1,
  input  logic [id_pipe_pkg::XLEN-1:0]   regrd_rs2,
  // Writeback port for forwarding
  input  logic                           regwr_en,
  input  logic [id_pipe_pkg::REG_AW-1:0] regwr_sel,
  input  logic [id_pipe_pkg::XLEN-1:0]   regwr_data,
  // Register usage
  output logic [id_pipe_pkg::REG_AW-1:0] rs1,
  output logic [id_pipe_pkg::REG_AW-1:0] rs2,
  output logic [id_pipe_pkg::REG_AW-1:0] rd,
  output logic                           rs1_used,
  output logic                           rs2_used,
  output logic                           rd_write,
  // Decode record
  output logic [id_pipe_pkg::XLEN-1:0]   decode_pc,
  output logic [id_pipe_pkg::XLEN-1:0]   decode_ir,
  output rv_isa_pkg::aluop_e             decode_aluop,
  output logic [id_pipe_pkg::XLEN-1:0]   decode_op1,
  output logic [id_pipe_pkg::XLEN-1:0]   decode_op2,
  output logic [id_pipe_pkg::XLEN-1:0]   decode_addr,
  output logic                           decode_regwr_alu,
  output logic                           decode_jump,
  output logic                           decode_branch,
  output logic                           decode_vld
);

  import rv_isa_pkg::*;
  import id_pipe_pkg::*;

  opcode_e         op;
  logic [2:0]      funct3;
  logic            alt_op;
  brop_e           br_op;

  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;

  aluop_e          aluop;
  logic [XLEN-1:0] op1;
  logic [XLEN-1:0] op2;
  logic            regwr_alu;
  logic            taken;

  logic [XLEN-1:0] base;
  logic [XLEN-1:0] offset;
  logic [XLEN-1:0] addr_raw;
  logic            align;

  // ==============================
  // Instruction fields
  // ==============================

  assign op     = opcode_e'(fetch_ir[6:2]);
  assign rd     = fetch_ir[11:7];
  assign funct3 = fetch_ir[14:12];
  assign rs1    = fetch_ir[19:15];
  assign rs2    = fetch_ir[24:20];
  // funct7 bit 5, SUB and SRA select
  assign alt_op = fetch_ir[30];
  assign br_op  = brop_e'(funct3);

  // Source and destination usage for the scoreboard
  assign rs1_used  = op inside {OP_JALR, OP_BRANCH, OP_OPIMM, OP_OP};
  assign rs2_used  = op inside {OP_BRANCH, OP_OP};
  assign rd_write  = op inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_OPIMM, OP_OP};
  assign regwr_alu = rd_write && (rd != '0);

  // Same-cycle writeback beats the array, never for x0
  assign rs1_data = (regwr_en && (regwr_sel != '0) && (regwr_sel == rs1)) ?
                    regwr_data : regrd_rs1;
  assign rs2_data = (regwr_en && (regwr_sel != '0) && (regwr_sel == rs2)) ?
                    regwr_data : regrd_rs2;

  // ==============================
  // Operand and address selection
  // ==============================

  always_comb begin
    // Defaults give PC + 4 with ADD
    aluop  = ALU_ADD;
    op1    = fetch_pc;
    op2    = WORD_FOUR;
    base   = fetch_pc;
    offset = WORD_FOUR;
    align  = 1'b0;
    case (op)
      OP_LUI: begin
        op1 = WORD_ZERO;
        op2 = immediate;
      end
      OP_AUIPC: begin
        op2 = immediate;
      end
      // Link value PC + 4 goes through the ALU
      OP_JAL: begin
        offset = immediate;
      end
      OP_JALR: begin
        base   = rs1_data;
        offset = immediate;
        align  = 1'b1;
      end
      OP_BRANCH: begin
        offset = immediate;
      end
      OP_OPIMM: begin
        // Only shifts carry funct7 in the immediate
        if (funct3 == 3'b001 || funct3 == 3'b101) begin
          aluop = aluop_e'({alt_op, funct3});
        end else begin
          aluop = aluop_e'({1'b0, funct3});
        end
        op1 = rs1_data;
        op2 = immediate;
      end
      OP_OP: begin
        aluop = aluop_e'({alt_op, funct3});
        op1   = rs1_data;
        op2   = rs2_data;
      end
      default: begin
      end
    endcase
  end

  // Target adder, JALR clears bit 0
  assign addr_raw = base + offset;

  branch_cmp u_branch_cmp (
    .op       (br_op),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .taken    (taken)
  );

  // ==============================
  // Decode register
  // ==============================

  // New issue keeps it full, drain or flush empties it
  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      decode_vld <= 1'b0;
    end else if (flush) begin
      decode_vld <= 1'b0;
    end else if (issue) begin
      decode_vld <= 1'b1;
    end else if (decode_rdy) begin
      decode_vld <= 1'b0;
    end
  end

  // Payload holds between issues
  always_ff @(posedge clk) begin
    if (issue) begin
      decode_pc        <= fetch_pc;
      decode_ir        <= fetch_ir;
      decode_aluop     <= aluop;
      decode_op1       <= op1;
      decode_op2       <= op2;
      decode_addr      <= {addr_raw[XLEN-1:1], addr_raw[0] & !align};
      decode_regwr_alu <= regwr_alu;
      decode_jump      <= (op == OP_JAL) || (op == OP_JALR);
      decode_branch    <= taken && (op == OP_BRANCH);
    end
  end

endmodule

// ==== hazard_ctrl.sv ====
// ==============================
// Register scoreboard and fetch handshake control for decode
// ==============================

`timescale 1ns/1ns

module hazard_ctrl (
  input  logic                           clk,
  input  logic                           rstz,
  input  logic                           flush,
  // Fetch side
  input  logic                           fetch_vld,
  output logic                           fetch_rdy,
  // Decode register occupancy
  input  logic                           decode_vld,
  input  logic                           decode_rdy,
  // Register usage of the instruction in decode
  input  logic                           rs1_used,
  input  logic                           rs2_used,
  input  logic                           rd_write,
  input  logic [id_pipe_pkg::REG_AW-1:0] rs1,
  input  logic [id_pipe_pkg::REG_AW-1:0] rs2,
  input  logic [id_pipe_pkg::REG_AW-1:0] rd,
  // Writeback port
  input  logic                           regwr_en,
  input  logic [id_pipe_pkg::REG_AW-1:0] regwr_sel,
  // Load strobe to the decode register
  output logic                           issue
);

  import id_pipe_pkg::*;

  // One pending-write bit per register
  logic [NUM_REGS-1:0] busy;
  logic [NUM_REGS-1:0] busy_nxt;

  logic rs1_hazard;
  logic rs2_hazard;
  logic stall;

  // ==============================
  // Stall decision
  // ==============================

  // Busy source stalls unless its writeback lands this cycle
  assign rs1_hazard = rs1_used && busy[rs1] && !(regwr_en && (regwr_sel == rs1));
  assign rs2_hazard = rs2_used && busy[rs2] && !(regwr_en && (regwr_sel == rs2));
  assign stall      = rs1_hazard || rs2_hazard;

  // Room in the decode register, no hazard, no flush
  assign fetch_rdy = (!decode_vld || decode_rdy) && !stall && !flush;
  assign issue     = fetch_vld && fetch_rdy;

  // ==============================
  // Scoreboard
  // ==============================

  always_comb begin
    busy_nxt = busy;
    // Writeback retires the register
    if (regwr_en) begin
      busy_nxt[regwr_sel] = 1'b0;
    end
    // New destination takes priority over a colliding writeback
    // x0 never becomes busy
    if (issue && rd_write && (rd != '0)) begin
      busy_nxt[rd] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      busy <= '0;
    end else if (flush) begin
      busy <= '0;
    end else begin
      busy <= busy_nxt;
    end
  end

endmodule

// ==== branch_cmp.sv ====
// ==============================
// Branch condition evaluation on two register operands
// ==============================

`timescale 1ns/1ns

module branch_cmp (
  input  rv_isa_pkg::brop_e            op,
  input  logic [id_pipe_pkg::XLEN-1:0] rs1_data,
  input  logic [id_pipe_pkg::XLEN-1:0] rs2_data,
  output logic                         taken
);

  import rv_isa_pkg::*;

  // Shared comparators
  logic eq;
  logic lt;
  logic ltu;

  assign eq  = (rs1_data == rs2_data);
  assign lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign ltu = (rs1_data < rs2_data);

  always_comb begin
    case (op)
      BR_EQ:   taken = eq;
      BR_NE:   taken = !eq;
      BR_LT:   taken = lt;
      BR_GE:   taken = !lt;
      BR_LTU:  taken = ltu;
      BR_GEU:  taken = !ltu;
      // Reserved funct3 never branches
      default: taken = 1'b0;
    endcase
  end

endmodule

// ==== imm_gen.sv ====
// ==============================
// Immediate extraction for the RV32I formats, purely combinational
// ==============================

`timescale 1ns/1ns

module imm_gen (
  input  logic [id_pipe_pkg::XLEN-1:0] ir,
  output logic [id_pipe_pkg::XLEN-1:0] immediate
);

  import rv_isa_pkg::*;
  import id_pipe_pkg::*;

  // Major opcode selects the format
  opcode_e op;

  assign op = opcode_e'(ir[6:2]);

  always_comb begin
    case (op)
      // I format
      OP_OPIMM,
      OP_JALR,
      OP_LOAD: begin
        immediate = {{(XLEN-12){ir[31]}}, ir[31:20]};
      end
      // S format
      OP_STORE: begin
        immediate = {{(XLEN-12){ir[31]}}, ir[31:25], ir[11:7]};
      end
      // B format, even offsets only
      OP_BRANCH: begin
        immediate = {{(XLEN-12){ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
      end
      // U format in the upper 20 bits
      OP_LUI,
      OP_AUIPC: begin
        immediate = {ir[XLEN-1:12], 12'b0};
      end
      // J format, even offsets only
      OP_JAL: begin
        immediate = {{(XLEN-20){ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
      end
      // No immediate
      default: begin
        immediate = '0;
      end
    endcase
  end

endmodule

// ==== regfile.sv ====
// ==============================
// Integer register file with two async read ports and one write port
// ==============================

`timescale 1ns/1ns

module regfile (
  input  logic                            clk,
  input  logic                            rstz,
  // Read indices
  input  logic [id_pipe_pkg::REG_AW-1:0]  rs1,
  input  logic [id_pipe_pkg::REG_AW-1:0]  rs2,
  // Write port
  input  logic                            regwr_en,
  input  logic [id_pipe_pkg::REG_AW-1:0]  regwr_sel,
  input  logic [id_pipe_pkg::XLEN-1:0]    regwr_data,
  // Read data
  output logic [id_pipe_pkg::XLEN-1:0]    rs1_data,
  output logic [id_pipe_pkg::XLEN-1:0]    rs2_data
);

  import id_pipe_pkg::*;

  // Storage, entry 0 stays zero
  logic [XLEN-1:0] regs [NUM_REGS];

  // Write on the edge
  // x0 writes dropped
  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (regwr_en && (regwr_sel != '0)) begin
      regs[regwr_sel] <= regwr_data;
    end
  end

  // Combinational reads
  // x0 forced to zero
  assign rs1_data = (rs1 == '0) ? WORD_ZERO : regs[rs1];
  assign rs2_data = (rs2 == '0) ? WORD_ZERO : regs[rs2];

endmodule

// ==== id_pipe_pkg.sv ====
// ==============================
// Datapath sizes and operand constants of the decode pipeline
// ==============================

package id_pipe_pkg;

  // ==============================
  // Sizes
  // ==============================

  // Data and address width
  localparam int unsigned XLEN = 32;

  // Register index width
  localparam int unsigned REG_AW = 5;

  // Architectural register count
  localparam int unsigned NUM_REGS = 2 ** REG_AW;

  // ==============================
  // Operand constants
  // ==============================

  // Zero operand for LUI
  localparam logic [XLEN-1:0] WORD_ZERO = '0;

  // Instruction size, link address and default offset
  localparam logic [XLEN-1:0] WORD_FOUR = 4;

endpackage

// ==== rv_isa_pkg.sv ====
// ==============================
// RV32I field encodings for opcodes, ALU operations and branches
// Imported by the decode stage and its testbench
// ==============================

package rv_isa_pkg;

  // Major opcode, instruction bits 6:2
  typedef enum logic [4:0] {
    OP_LOAD   = 5'b00000,
    OP_OPIMM  = 5'b00100,
    OP_AUIPC  = 5'b00101,
    OP_STORE  = 5'b01000,
    OP_OP     = 5'b01100,
    OP_LUI    = 5'b01101,
    OP_BRANCH = 5'b11000,
    OP_JALR   = 5'b11001,
    OP_JAL    = 5'b11011,
    OP_SYSTEM = 5'b11100
  } opcode_e;

  // ALU operation as {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } aluop_e;

  // Branch condition, funct3 of the branch opcode
  // 3'b010 and 3'b011 are not defined
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } brop_e;

endpackage
